// File: flist.f
rtl/game_pkg.sv
rtl/key_if.sv
rtl/ps2_rx.sv
rtl/key_decoder.sv
rtl/block_contact.sv
rtl/player_motion.sv
rtl/collect_score.sv
rtl/platform_top.sv
sim/platform_tb.sv

// File: run.sh
#!/bin/sh
# build and run the platform testbench with Verilator
cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing -f flist.f --top-module platform_tb -o platform_sim
if [ $? -ne 0 ]; then
    echo "verilator build failed"
    exit 1
fi

./obj_dir/platform_sim > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if grep -q "test failed" "$LOG"; then
    exit 1
fi
exit 0

// File: sim/platform_tb.sv
`timescale 1ns/1ps
`default_nettype none

module platform_tb;

    localparam int STEP      = 20;
    localparam int PS2_HALF  = 8;
    localparam int NUM_TESTS = 5;
    localparam int MAX_BYTES = 6;
    // eleven bits of two half-periods each plus the largest gap
    localparam int FRAME_CYCLES = 11 * 2 * PS2_HALF + 3;

    logic       clk;
    logic       reset_i;
    logic       ps2_clk;
    logic       ps2_data;
    logic [9:0] player_x;
    logic [8:0] player_y;
    logic       airborne;
    logic       facing;
    logic [3:0] score;

    int errors      = 0;
    int cycle_cnt   = 0;
    int cycle_limit = 0;
    int min_y       = 511;

    // one row per test with bytes sent, wait in motion ticks and expected outputs
    string      test_name  [NUM_TESTS] = '{"idle", "walk_right", "jump", "walk_left", "restart"};
    logic [7:0] test_bytes [NUM_TESTS][MAX_BYTES] = '{
        '{8'h00, 8'h00, 8'h00, 8'h00, 8'h00, 8'h00},
        '{8'h23, 8'h00, 8'h00, 8'h00, 8'h00, 8'h00},
        '{8'hF0, 8'h23, 8'h1D, 8'hF0, 8'h1D, 8'h00},
        '{8'h1C, 8'h00, 8'h00, 8'h00, 8'h00, 8'h00},
        '{8'hF0, 8'h1C, 8'h23, 8'hF0, 8'h23, 8'h2D}
    };
    int test_len   [NUM_TESTS] = '{0, 1, 5, 1, 6};
    int test_wait  [NUM_TESTS] = '{10, 200, 100, 200, 5};
    // 144 is the wall at x 160 less the player width
    int exp_x      [NUM_TESTS] = '{0, 144, 144, 0, 0};
    int exp_y      [NUM_TESTS] = '{184, 184, 184, 184, 184};
    // jump peak is 40 pixels above the floor line
    int exp_min_y  [NUM_TESTS] = '{184, 184, 144, 184, 184};
    int exp_score  [NUM_TESTS] = '{0, 1, 1, 1, 1};
    int exp_air    [NUM_TESTS] = '{0, 0, 0, 0, 0};
    // 1 is facing right
    int exp_face   [NUM_TESTS] = '{1, 1, 1, 0, 1};

    platform_top #(
        .STEP_CYCLES(STEP)
    ) UUT (
        .clk       (clk),
        .reset_i   (reset_i),
        .ps2_clk_i (ps2_clk),
        .ps2_data_i(ps2_data),
        .player_x_o(player_x),
        .player_y_o(player_y),
        .airborne_o(airborne),
        .facing_o  (facing),
        .score_o   (score)
    );

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    always @(posedge clk) begin
        cycle_cnt <= cycle_cnt + 1;
        if (cycle_limit > 0 && cycle_cnt >= cycle_limit) begin
            $display("timeout: run went past %0d cycles", cycle_limit);
            $display("test failed");
            $finish;
        end
    end

    // advance one clock and track the highest point reached
    task automatic step_clock();
        @(posedge clk);
        #10;
        if (int'(player_y) < min_y) begin
            min_y = int'(player_y);
        end
    endtask

    task automatic wait_cycles(input int n);
        for (int i = 0; i < n; i++) begin
            step_clock();
        end
    endtask

    // start, eight data bits lsb first, odd parity, stop
    task automatic send_byte(input logic [7:0] b);
        logic [10:0] frame;
        int          gap;
        frame = {1'b1, ~^b, b, 1'b0};
        for (int i = 0; i < 11; i++) begin
            ps2_data = frame[i];
            wait_cycles(PS2_HALF);
            ps2_clk = 1'b0;
            wait_cycles(PS2_HALF);
            ps2_clk = 1'b1;
        end
        gap = int'($urandom % 4);
        wait_cycles(gap);
    endtask

    task automatic check_value(input string name, input string what,
                               input int expected, input int actual);
        if (expected != actual) begin
            $display("CHECK FAILED %s %s expected %0d actual %0d", name, what, expected, actual);
            errors++;
        end
    endtask

    initial begin
        int total_wait;
        int total_bytes;
        int row_errors;
        void'($urandom(32'h3d86bd2e));
        reset_i  = 1'b1;
        ps2_clk  = 1'b1;
        ps2_data = 1'b1;

        total_wait  = 0;
        total_bytes = 0;
        for (int t = 0; t < NUM_TESTS; t++) begin
            total_wait  += test_wait[t];
            total_bytes += test_len[t];
        end
        cycle_limit = 2 * total_wait * STEP + total_bytes * FRAME_CYCLES + 5;

        wait_cycles(5);
        reset_i = 1'b0;

        for (int t = 0; t < NUM_TESTS; t++) begin
            row_errors = errors;
            min_y = 511;
            for (int k = 0; k < test_len[t]; k++) begin
                send_byte(test_bytes[t][k]);
            end
            wait_cycles(test_wait[t] * STEP);
            check_value(test_name[t], "x", exp_x[t], int'(player_x));
            check_value(test_name[t], "y", exp_y[t], int'(player_y));
            check_value(test_name[t], "min_y", exp_min_y[t], min_y);
            check_value(test_name[t], "score", exp_score[t], int'(score));
            check_value(test_name[t], "airborne", exp_air[t], int'(airborne));
            check_value(test_name[t], "facing", exp_face[t], int'(facing));
            if (errors == row_errors) begin
                $display("[ok]  %s", test_name[t]);
            end else begin
                $display("[bad] %s", test_name[t]);
            end
        end

        $display("tests run: %0d, checks failed: %0d", NUM_TESTS, errors);
        if (errors == 0) begin
            $display("test passed");
        end else begin
            $display("test failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: rtl/platform_top.sv
`timescale 1ns/1ps
`default_nettype none

module platform_top #(
    parameter int STEP_CYCLES = 250000
) (
    input  wire logic                    clk,
    input  wire logic                    reset_i,
    input  wire logic                    ps2_clk_i,
    input  wire logic                    ps2_data_i,
    output game_pkg::coord_x_t           player_x_o,
    output game_pkg::coord_y_t           player_y_o,
    output logic                         airborne_o,
    output logic                         facing_o,
    output logic [game_pkg::SCORE_W-1:0] score_o
);

    import game_pkg::*;

    logic [7:0] rx_byte;
    logic       rx_valid;
    coord_x_t   pos_x;
    coord_y_t   pos_y;
    logic       restart;

    key_if kif ();

    ps2_rx u_rx (
        .clk       (clk),
        .reset_i   (reset_i),
        .ps2_clk_i (ps2_clk_i),
        .ps2_data_i(ps2_data_i),
        .data_o    (rx_byte),
        .valid_o   (rx_valid)
    );

    key_decoder u_dec (
        .clk    (clk),
        .reset_i(reset_i),
        .data_i (rx_byte),
        .valid_i(rx_valid),
        .kif    (kif.decoder)
    );

    player_motion #(
        .STEP_CYCLES(STEP_CYCLES)
    ) u_motion (
        .clk       (clk),
        .reset_i   (reset_i),
        .kif       (kif.motion),
        .x_o       (pos_x),
        .y_o       (pos_y),
        .airborne_o(airborne_o),
        .facing_o  (facing_o),
        .restart_o (restart)
    );

    collect_score u_score (
        .clk      (clk),
        .reset_i  (reset_i),
        .x_i      (pos_x),
        .y_i      (pos_y),
        .restart_i(restart),
        .score_o  (score_o)
    );

    assign player_x_o = pos_x;
    assign player_y_o = pos_y;

endmodule

`default_nettype wire

// File: rtl/collect_score.sv
`timescale 1ns/1ps
`default_nettype none

module collect_score (
    input  wire logic                        clk,
    input  wire logic                        reset_i,
    input  wire game_pkg::coord_x_t          x_i,
    input  wire game_pkg::coord_y_t          y_i,
    input  wire logic                        restart_i,
    output logic [game_pkg::SCORE_W-1:0]     score_o
);

    import game_pkg::*;

    logic [NUM_FLAKES-1:0] present;
    logic [NUM_FLAKES-1:0] hit;
    logic [SCORE_W-1:0]    score_q;
    logic [SCORE_W-1:0]    score_next;

    for (genvar i = 0; i < NUM_FLAKES; i++) begin : g_flake
        logic ov_x, ov_y;

        assign ov_x = ({1'b0, x_i} < {1'b0, FLAKE_X[i]} + 11'(FLAKE_W))
                   && ({1'b0, FLAKE_X[i]} < {1'b0, x_i} + 11'(PLAYER_W));
        assign ov_y = ({1'b0, y_i} < {1'b0, FLAKE_Y[i]} + 10'(FLAKE_H))
                   && ({1'b0, FLAKE_Y[i]} < {1'b0, y_i} + 10'(PLAYER_H));
        // no pickup on the teleport cycle
        assign hit[i] = present[i] & ov_x & ov_y & ~restart_i;
    end

    // saturating add, one per flake hit
    always_comb begin
        score_next = score_q;
        for (int i = 0; i < NUM_FLAKES; i++) begin
            if (hit[i] && score_next != '1) begin
                score_next = score_next + SCORE_W'(1);
            end
        end
    end

    always_ff @(posedge clk) begin
        if (reset_i) begin
            present <= '1;
            score_q <= '0;
        end else begin
            present <= present & ~hit;
            score_q <= score_next;
        end
    end

    assign score_o = score_q;

endmodule

`default_nettype wire

// File: rtl/player_motion.sv
`timescale 1ns/1ps
`default_nettype none

module player_motion #(
    parameter int STEP_CYCLES = 250000
) (
    input  wire logic               clk,
    input  wire logic               reset_i,
    key_if.motion                   kif,
    output game_pkg::coord_x_t      x_o,
    output game_pkg::coord_y_t      y_o,
    output logic                    airborne_o,
    output logic                    facing_o,
    output logic                    restart_o
);

    import game_pkg::*;

    localparam int CNT_W  = (STEP_CYCLES > 1) ? $clog2(STEP_CYCLES) : 1;
    localparam int RISE_W = $clog2(JUMP_HEIGHT + 1);

    logic [CNT_W-1:0]  tick_cnt;
    logic              tick;
    coord_x_t          x_q;
    coord_y_t          y_q;
    logic              facing_q;
    logic              rising;
    logic [RISE_W-1:0] risen;
    logic              restart_q;
    logic              touch_down, touch_up, touch_right, touch_left;

    block_contact u_contact (
        .x_i          (x_q),
        .y_i          (y_q),
        .touch_down_o (touch_down),
        .touch_up_o   (touch_up),
        .touch_right_o(touch_right),
        .touch_left_o (touch_left)
    );

    // free-running motion tick
    assign tick = (tick_cnt == CNT_W'(STEP_CYCLES - 1));

    always_ff @(posedge clk) begin
        if (reset_i || tick) begin
            tick_cnt <= '0;
        end else begin
            tick_cnt <= tick_cnt + 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (reset_i) begin
            x_q       <= START_X;
            y_q       <= START_Y;
            facing_q  <= 1'b1;
            rising    <= 1'b0;
            risen     <= '0;
            restart_q <= 1'b0;
        end else begin
            restart_q <= kif.restart;
            if (kif.restart) begin
                x_q      <= START_X;
                y_q      <= START_Y;
                facing_q <= 1'b1;
                rising   <= 1'b0;
                risen    <= '0;
            end else if (tick) begin
                // left wins when both keys are held
                if (kif.keys.left) begin
                    facing_q <= 1'b0;
                    if (!touch_left && x_q != '0) begin
                        x_q <= x_q - 10'd1;
                    end
                end else if (kif.keys.right) begin
                    facing_q <= 1'b1;
                    if (!touch_right) begin
                        x_q <= x_q + 10'd1;
                    end
                end

                if (rising) begin
                    if (risen < RISE_W'(JUMP_HEIGHT) && !touch_up) begin
                        y_q   <= y_q - 9'd1;
                        risen <= risen + 1'b1;
                    end else begin
                        rising <= 1'b0;
                        risen  <= '0;
                    end
                end else if (kif.keys.jump && touch_down) begin
                    rising <= 1'b1;
                end else if (!touch_down) begin
                    y_q <= y_q + 9'd1;
                end
            end
        end
    end

    assign x_o        = x_q;
    assign y_o        = y_q;
    // 1 means facing right
    assign facing_o   = facing_q;
    assign airborne_o = ~touch_down;
    // marks the cycle the start position appears
    assign restart_o  = restart_q;

endmodule

`default_nettype wire

// File: rtl/block_contact.sv
`timescale 1ns/1ps
`default_nettype none

module block_contact (
    input  wire game_pkg::coord_x_t x_i,
    input  wire game_pkg::coord_y_t y_i,
    output logic                    touch_down_o,
    output logic                    touch_up_o,
    output logic                    touch_right_o,
    output logic                    touch_left_o
);

    import game_pkg::*;

    // one extra bit so box edges near the screen limit do not wrap
    logic [10:0] px0, px1;
    logic [9:0]  py0, py1;
    logic [NUM_BLOCKS-1:0] down, up, right, left;

    assign px0 = {1'b0, x_i};
    assign px1 = px0 + 11'(PLAYER_W);
    assign py0 = {1'b0, y_i};
    assign py1 = py0 + 10'(PLAYER_H);

    for (genvar i = 0; i < NUM_BLOCKS; i++) begin : g_block
        logic [10:0] bx0, bx1;
        logic [9:0]  by0, by1;
        logic        ov_x, ov_y;

        assign bx0 = {1'b0, BLOCK_X[i]};
        assign bx1 = bx0 + 11'(BLOCK_W);
        assign by0 = {1'b0, BLOCK_Y[i]};
        assign by1 = by0 + 10'(BLOCK_H);

        // strict overlap, so a shared corner is not contact
        assign ov_x = (px0 < bx1) && (bx0 < px1);
        assign ov_y = (py0 < by1) && (by0 < py1);

        assign down[i]  = ov_x && (by0 == py1);
        assign up[i]    = ov_x && (by1 == py0);
        assign right[i] = ov_y && (bx0 == px1);
        assign left[i]  = ov_y && (bx1 == px0);
    end

    assign touch_down_o  = |down;
    assign touch_up_o    = |up;
    assign touch_right_o = |right;
    assign touch_left_o  = |left;

endmodule

`default_nettype wire

// File: rtl/key_decoder.sv
`timescale 1ns/1ps
`default_nettype none

module key_decoder (
    input  wire logic       clk,
    input  wire logic       reset_i,
    input  wire logic [7:0] data_i,
    input  wire logic       valid_i,
    key_if.decoder          kif
);

    import game_pkg::*;

    key_mask_t keys_q;
    key_mask_t keys_next;
    logic      restart_q;
    logic      restart_next;
    logic      event_q;
    logic      break_q;

    always_comb begin
        keys_next    = keys_q;
        restart_next = 1'b0;
        if (valid_i && data_i != BREAK_CODE) begin
            case (data_i)
                KEY_W:   keys_next.jump  = ~break_q;
                KEY_A:   keys_next.left  = ~break_q;
                KEY_D:   keys_next.right = ~break_q;
                KEY_R:   restart_next    = ~break_q;
                default: ;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (reset_i) begin
            keys_q    <= '0;
            restart_q <= 1'b0;
            event_q   <= 1'b0;
            break_q   <= 1'b0;
        end else begin
            keys_q    <= keys_next;
            restart_q <= restart_next;
            event_q   <= (keys_next != keys_q) | restart_next;
            if (valid_i) begin
                // prefix applies to the next code only
                break_q <= (data_i == BREAK_CODE);
            end
        end
    end

    assign kif.keys        = keys_q;
    assign kif.restart     = restart_q;
    assign kif.event_valid = event_q;
    assign kif.any_break   = break_q;

endmodule

`default_nettype wire

// File: rtl/ps2_rx.sv
`timescale 1ns/1ps
`default_nettype none

module ps2_rx (
    input  wire logic       clk,
    input  wire logic       reset_i,
    input  wire logic       ps2_clk_i,
    input  wire logic       ps2_data_i,
    output logic      [7:0] data_o,
    output logic            valid_o
);

    logic [1:0]  clk_sync;
    logic [1:0]  data_sync;
    logic        clk_prev;
    logic        fall;
    logic [3:0]  bit_cnt;
    logic [9:0]  shift_q;
    logic [10:0] frame;
    logic        frame_ok;

    // two-stage synchronizers on both lines
    always_ff @(posedge clk) begin
        if (reset_i) begin
            clk_sync  <= 2'b11;
            data_sync <= 2'b11;
            clk_prev  <= 1'b1;
        end else begin
            clk_sync  <= {clk_sync[0], ps2_clk_i};
            data_sync <= {data_sync[0], ps2_data_i};
            clk_prev  <= clk_sync[1];
        end
    end

    assign fall = clk_prev & ~clk_sync[1];

    // stop bit arrives last, lands in the top position
    assign frame    = {data_sync[1], shift_q};
    assign frame_ok = ~frame[0] & frame[10] & (^frame[9:1]);

    always_ff @(posedge clk) begin
        if (reset_i) begin
            bit_cnt <= 4'd0;
            valid_o <= 1'b0;
        end else begin
            valid_o <= 1'b0;
            if (fall) begin
                if (bit_cnt == 4'd10) begin
                    bit_cnt <= 4'd0;
                    valid_o <= frame_ok;
                end else if (bit_cnt != 4'd0 || !data_sync[1]) begin
                    // wait for a low start bit before counting
                    bit_cnt <= bit_cnt + 4'd1;
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        if (fall) begin
            shift_q <= {data_sync[1], shift_q[9:1]};
            if (bit_cnt == 4'd10) begin
                data_o <= frame[8:1];
            end
        end
    end

endmodule

`default_nettype wire

// File: rtl/key_if.sv
`timescale 1ns/1ps
`default_nettype none

interface key_if;
    import game_pkg::*;

    key_mask_t keys;
    // one cycle on an R make code
    logic      restart;
    // one cycle whenever keys change or restart fires
    logic      event_valid;
    logic      any_break;

    modport decoder (output keys, output restart, output event_valid, output any_break);
    modport motion  (input keys, input restart);

endinterface

`default_nettype wire

// File: rtl/game_pkg.sv
`default_nettype none

package game_pkg;

    typedef logic [9:0] coord_x_t;
    typedef logic [8:0] coord_y_t;

    typedef struct packed {
        logic jump;
        logic left;
        logic right;
    } key_mask_t;

    // player and block boxes
    localparam int PLAYER_W = 16;
    localparam int PLAYER_H = 16;
    localparam int BLOCK_W  = 16;
    localparam int BLOCK_H  = 16;

    // 16 floor tiles, then the wall, then the ceiling platform
    localparam int NUM_BLOCKS = 18;
    localparam coord_x_t BLOCK_X [NUM_BLOCKS] = '{
        10'd0,   10'd16,  10'd32,  10'd48,  10'd64,  10'd80,  10'd96,  10'd112,
        10'd128, 10'd144, 10'd160, 10'd176, 10'd192, 10'd208, 10'd224, 10'd240,
        10'd160, 10'd0
    };
    localparam coord_y_t BLOCK_Y [NUM_BLOCKS] = '{
        9'd200, 9'd200, 9'd200, 9'd200, 9'd200, 9'd200, 9'd200, 9'd200,
        9'd200, 9'd200, 9'd200, 9'd200, 9'd200, 9'd200, 9'd200, 9'd200,
        9'd184, 9'd136
    };

    localparam coord_x_t START_X = 10'd0;
    localparam coord_y_t START_Y = 9'd184;

    localparam int JUMP_HEIGHT = 40;

    // second flake sits out of reach
    localparam int NUM_FLAKES = 2;
    localparam coord_x_t FLAKE_X [NUM_FLAKES] = '{10'd80, 10'd300};
    localparam coord_y_t FLAKE_Y [NUM_FLAKES] = '{9'd188, 9'd100};
    localparam int FLAKE_W = 8;
    localparam int FLAKE_H = 8;

    // set 2 scan codes
    localparam logic [7:0] KEY_W      = 8'h1D;
    localparam logic [7:0] KEY_A      = 8'h1C;
    localparam logic [7:0] KEY_D      = 8'h23;
    localparam logic [7:0] KEY_R      = 8'h2D;
    localparam logic [7:0] BREAK_CODE = 8'hF0;

    localparam int SCORE_W = 4;

endpackage

`default_nettype wire
